// ==== design/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] reg_addr_t;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDIU = 6'h09,
        OP_SLTI  = 6'h0A,
        OP_ANDI  = 6'h0C,
        OP_ORI   = 6'h0D,
        OP_XORI  = 6'h0E,
        OP_LUI   = 6'h0F,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2B
    } opcode_t;

    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2A,
        FN_SLTU = 6'h2B
    } funct_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_PASS_B // LUI
    } alu_op_t;

    typedef enum logic [1:0] {
        S_FETCH,
        S_EXECUTE,
        S_MEMORY
    } state_t;

    typedef struct packed {
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;        // Destination, rt or rd
        word_t imm;
        logic [4:0] shamt;
        alu_op_t alu_op;
        logic use_imm;
        logic use_shamt;
        logic reg_write;
        logic is_load;
        logic is_store;
        logic is_beq;
        logic is_bne;
        logic is_jump;
        logic is_jr;
        logic [25:0] jidx;
    } decoded_t;

    typedef struct packed {
        logic read;
        logic write;
        word_t addr;          // Byte address
        word_t wdata;         // Big-endian
    } bus_req_t;

    localparam word_t RESET_VECTOR = 32'hBFC0_0000;
    localparam reg_addr_t REG_V0 = 5'd2;

endpackage

`default_nettype wire

// ==== design/mips_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module mips_decoder import mips_pkg::*; (
    input  word_t instr,
    output decoded_t dec
);
    opcode_t op;
    funct_t fn;
    logic [15:0] imm16;

    assign op = opcode_t'(instr[31:26]);
    assign fn = funct_t'(instr[5:0]);
    assign imm16 = instr[15:0];

    always_comb begin
        dec = '0;
        dec.rs = instr[25:21];
        dec.rt = instr[20:16];
        dec.rd = instr[20:16];              // I-type writes rt
        dec.shamt = instr[10:6];
        dec.jidx = instr[25:0];
        dec.imm = {{16{imm16[15]}}, imm16};
        dec.alu_op = ALU_ADD;
        dec.use_imm = 1'b1;

        case (op)
            OP_RTYPE: begin
                dec.rd = instr[15:11];
                dec.use_imm = 1'b0;
                dec.reg_write = 1'b1;
                case (fn)
                    FN_SLL: begin
                        dec.alu_op = ALU_SLL;
                        dec.use_shamt = 1'b1;
                    end
                    FN_SRL: begin
                        dec.alu_op = ALU_SRL;
                        dec.use_shamt = 1'b1;
                    end
                    FN_SRA: begin
                        dec.alu_op = ALU_SRA;
                        dec.use_shamt = 1'b1;
                    end
                    FN_JR: begin
                        dec.is_jr = 1'b1;
                        dec.reg_write = 1'b0;
                    end
                    FN_ADDU: dec.alu_op = ALU_ADD;
                    FN_SUBU: dec.alu_op = ALU_SUB;
                    FN_AND:  dec.alu_op = ALU_AND;
                    FN_OR:   dec.alu_op = ALU_OR;
                    FN_XOR:  dec.alu_op = ALU_XOR;
                    FN_SLT:  dec.alu_op = ALU_SLT;
                    FN_SLTU: dec.alu_op = ALU_SLTU;
                    default: dec.reg_write = 1'b0;   // Unknown funct is a no-op
                endcase
            end
            OP_J:     dec.is_jump = 1'b1;
            OP_BEQ:   dec.is_beq = 1'b1;
            OP_BNE:   dec.is_bne = 1'b1;
            OP_ADDIU: dec.reg_write = 1'b1;
            OP_SLTI: begin
                dec.alu_op = ALU_SLT;
                dec.reg_write = 1'b1;
            end
            OP_ANDI: begin
                dec.alu_op = ALU_AND;
                dec.imm = {16'b0, imm16};
                dec.reg_write = 1'b1;
            end
            OP_ORI: begin
                dec.alu_op = ALU_OR;
                dec.imm = {16'b0, imm16};
                dec.reg_write = 1'b1;
            end
            OP_XORI: begin
                dec.alu_op = ALU_XOR;
                dec.imm = {16'b0, imm16};
                dec.reg_write = 1'b1;
            end
            OP_LUI: begin
                dec.alu_op = ALU_PASS_B;
                dec.imm = {imm16, 16'b0};
                dec.reg_write = 1'b1;
            end
            OP_LW: begin
                dec.is_load = 1'b1;
                dec.reg_write = 1'b1;
            end
            OP_SW:    dec.is_store = 1'b1;
            default: ;                               // No-op
        endcase
    end

endmodule

`default_nettype wire

// ==== design/mips_alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module mips_alu import mips_pkg::*; (
    input  word_t a,
    input  word_t b,
    input  logic [4:0] shamt,
    input  alu_op_t op,
    output word_t result
);

    always_comb begin
        case (op)
            ALU_ADD:    result = a + b;
            ALU_SUB:    result = a - b;
            ALU_AND:    result = a & b;
            ALU_OR:     result = a | b;
            ALU_XOR:    result = a ^ b;
            ALU_SLT:    result = {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU:   result = {31'b0, a < b};
            ALU_SLL:    result = b << shamt;
            ALU_SRL:    result = b >> shamt;
            ALU_SRA:    result = word_t'($signed(b) >>> shamt);
            ALU_PASS_B: result = b;
            default:    result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/mips_reg_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module mips_reg_file import mips_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  reg_addr_t rs_addr,
    input  reg_addr_t rt_addr,
    input  logic wr_en,
    input  reg_addr_t wr_addr,
    input  word_t wr_data,
    output word_t rs_val,
    output word_t rt_val,
    output word_t register_v0
);
    word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != 5'd0) begin    // $zero stays zero
            regs[wr_addr] <= wr_data;
        end
    end

    assign rs_val = regs[rs_addr];
    assign rt_val = regs[rt_addr];
    assign register_v0 = regs[REG_V0];

endmodule

`default_nettype wire

// ==== design/mips_control.sv ====
`timescale 1ns/100ps
`default_nettype none

module mips_control import mips_pkg::*; #(
    parameter word_t reset_vector = RESET_VECTOR
) (
    input  logic clk,
    input  logic reset,
    input  word_t rdata,
    input  logic fetch_stall,
    input  logic data_stall,
    input  decoded_t dec,
    input  word_t rs_val,
    input  word_t rt_val,
    output word_t instr,
    output bus_req_t fetch_req,
    output bus_req_t data_req,
    output logic wr_en,
    output reg_addr_t wr_addr,
    output word_t wr_data,
    output logic active
);
    state_t state;
    word_t pc;
    word_t ir;
    logic fresh;                 // First EXECUTE cycle, rdata holds the instruction
    logic branch_pending;
    word_t branch_target;

    word_t alu_a;
    word_t alu_b;
    logic [4:0] alu_shamt;
    word_t alu_result;
    logic is_branch;
    logic take;
    logic exec_done;
    word_t target;

    assign active = !(state == S_FETCH && pc == '0);
    assign instr = (state == S_EXECUTE && fresh) ? rdata : ir;

    assign is_branch = dec.is_beq || dec.is_bne;
    assign alu_a = is_branch ? pc : rs_val;
    assign alu_b = is_branch ? (dec.imm << 2) : (dec.use_imm ? dec.imm : rt_val);
    assign alu_shamt = dec.use_shamt ? dec.shamt : alu_a[4:0];

    mips_alu alu_i (
        .a(alu_a),
        .b(alu_b),
        .shamt(alu_shamt),
        .op(dec.alu_op),
        .result(alu_result)
    );

    assign take = (dec.is_beq && rs_val == rt_val) || (dec.is_bne && rs_val != rt_val)
                  || dec.is_jump || dec.is_jr;

    always_comb begin
        if (dec.is_jump) begin
            target = {pc[31:28], dec.jidx, 2'b00};
        end else if (dec.is_jr) begin
            target = rs_val;
        end else begin
            target = alu_result;              // pc + offset
        end
    end

    assign exec_done = state == S_EXECUTE && !(dec.is_load && data_stall);

    assign fetch_req.read = state == S_FETCH && active;
    assign fetch_req.write = 1'b0;
    assign fetch_req.addr = pc;
    assign fetch_req.wdata = '0;

    assign data_req.read = state == S_EXECUTE && dec.is_load;
    assign data_req.write = state == S_MEMORY && dec.is_store;
    assign data_req.addr = alu_result;
    assign data_req.wdata = rt_val;

    assign wr_en = dec.reg_write && ((state == S_EXECUTE && !dec.is_load)
                                     || (state == S_MEMORY && dec.is_load));
    assign wr_addr = dec.rd;
    assign wr_data = state == S_MEMORY ? rdata : alu_result;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_FETCH;
            pc <= reset_vector;
            fresh <= 1'b0;
            branch_pending <= 1'b0;
            branch_target <= '0;
        end else begin
            fresh <= fetch_req.read && !fetch_stall;
            case (state)
                S_FETCH: begin
                    if (active && !fetch_stall) begin
                        pc <= pc + 32'd4;
                        state <= S_EXECUTE;
                    end
                end
                S_EXECUTE: begin
                    if (exec_done) begin
                        if (branch_pending) begin      // Delay slot finished
                            pc <= branch_target;
                            branch_pending <= 1'b0;
                        end else if (take) begin
                            branch_target <= target;
                            branch_pending <= 1'b1;
                        end
                        state <= (dec.is_load || dec.is_store) ? S_MEMORY : S_FETCH;
                    end
                end
                S_MEMORY: begin
                    if (!(dec.is_store && data_stall)) begin
                        state <= S_FETCH;
                    end
                end
                default: state <= S_FETCH;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_EXECUTE) begin
            ir <= instr;
        end
    end

endmodule

`default_nettype wire

// ==== design/mips_bus_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module mips_bus_arbiter import mips_pkg::*; (
    input  bus_req_t fetch_req,
    input  bus_req_t data_req,
    input  logic waitrequest,
    input  word_t readdata,
    output logic fetch_stall,
    output logic data_stall,
    output word_t rdata,
    output word_t address,
    output logic read,
    output logic write,
    output word_t writedata,
    output logic [3:0] byteenable
);
    logic grant_data;
    bus_req_t sel;

    function automatic word_t swap_bytes(input word_t w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    assign grant_data = data_req.read || data_req.write;   // Data wins
    assign sel = grant_data ? data_req : fetch_req;

    assign address = {sel.addr[31:2], 2'b00};
    assign read = sel.read;
    assign write = sel.write;
    assign writedata = swap_bytes(sel.wdata);
    assign byteenable = 4'b1111;
    assign rdata = swap_bytes(readdata);

    assign fetch_stall = !grant_data && fetch_req.read && waitrequest;
    assign data_stall = grant_data && waitrequest;

endmodule

`default_nettype wire

// ==== design/mips_cpu_bus.sv ====
`timescale 1ns/100ps
`default_nettype none

module mips_cpu_bus import mips_pkg::*; #(
    parameter word_t reset_vector = RESET_VECTOR
) (
    input  logic clk,
    input  logic reset,
    output logic active,
    output word_t register_v0,

    output word_t address,
    output logic write,
    output logic read,
    input  logic waitrequest,
    output word_t writedata,
    output logic [3:0] byteenable,
    input  word_t readdata
);
    bus_req_t fetch_req;
    bus_req_t data_req;
    logic fetch_stall;
    logic data_stall;
    word_t rdata;
    word_t instr;
    decoded_t dec;
    word_t rs_val;
    word_t rt_val;
    logic wr_en;
    reg_addr_t wr_addr;
    word_t wr_data;

    mips_decoder decoder_i (
        .instr(instr),
        .dec(dec)
    );

    mips_control #(
        .reset_vector(reset_vector)
    ) control_i (
        .clk(clk),
        .reset(reset),
        .rdata(rdata),
        .fetch_stall(fetch_stall),
        .data_stall(data_stall),
        .dec(dec),
        .rs_val(rs_val),
        .rt_val(rt_val),
        .instr(instr),
        .fetch_req(fetch_req),
        .data_req(data_req),
        .wr_en(wr_en),
        .wr_addr(wr_addr),
        .wr_data(wr_data),
        .active(active)
    );

    mips_reg_file reg_file_i (
        .clk(clk),
        .reset(reset),
        .rs_addr(dec.rs),
        .rt_addr(dec.rt),
        .wr_en(wr_en),
        .wr_addr(wr_addr),
        .wr_data(wr_data),
        .rs_val(rs_val),
        .rt_val(rt_val),
        .register_v0(register_v0)
    );

    mips_bus_arbiter arbiter_i (
        .fetch_req(fetch_req),
        .data_req(data_req),
        .waitrequest(waitrequest),
        .readdata(readdata),
        .fetch_stall(fetch_stall),
        .data_stall(data_stall),
        .rdata(rdata),
        .address(address),
        .read(read),
        .write(write),
        .writedata(writedata),
        .byteenable(byteenable)
    );

endmodule

`default_nettype wire

// ==== bench/mips_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module mips_checker import mips_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic active,
    input  word_t register_v0,
    input  word_t address,
    input  logic read,
    input  logic write,
    input  word_t writedata,
    input  logic [3:0] byteenable,
    input  logic waitrequest,
    input  logic test_done,
    input  logic [127:0] test_name,
    input  int stall_rate,
    input  word_t exp_v0,
    input  logic exp_has_store,
    input  word_t exp_store_addr,
    input  word_t exp_store_data,        // As seen on writedata
    output int error_count,
    output int pass_count,
    output int fail_count
);
    int test_errors;
    int store_count;
    word_t store_addr;
    word_t store_data;
    logic first_pending;
    word_t prev_address;
    logic prev_read;
    logic prev_write;
    logic prev_wait;
    logic prev_reset;

    initial begin
        error_count = 0;
        pass_count = 0;
        fail_count = 0;
        test_errors = 0;
        store_count = 0;
        first_pending = 1'b1;
    end

    task automatic fault(input string msg);
        $display("Error in %0s: %0s", test_name, msg);
        test_errors++;
        error_count++;
    endtask

    task automatic mismatch(input string what, input word_t expected, input word_t actual);
        $display("Mismatch %0s %0s: expected %h, actual %h", test_name, what, expected, actual);
        test_errors++;
        error_count++;
    endtask

    always @(posedge clk) begin
        prev_address <= address;
        prev_read <= read;
        prev_write <= write;
        prev_wait <= waitrequest;
        prev_reset <= reset;
        if (reset) begin
            first_pending <= 1'b1;
            test_errors = 0;
            store_count = 0;
        end else begin
            if (first_pending) begin
                first_pending <= 1'b0;
                if (read !== 1'b1 || write !== 1'b0 || active !== 1'b1
                    || address !== RESET_VECTOR) begin
                    fault("first bus cycle after reset is not a fetch of the reset vector");
                end
            end
            if (!prev_reset && prev_wait && (prev_read || prev_write)
                && (address !== prev_address || read !== prev_read || write !== prev_write)) begin
                fault("request changed while waitrequest was high");
            end
            if (active === 1'b0 && (read !== 1'b0 || write !== 1'b0)) begin
                fault("bus activity after the core halted");
            end
            if (write === 1'b1 && waitrequest === 1'b0) begin    // Accepted store
                store_count++;
                store_addr = address;
                store_data = writedata;
                if (byteenable !== 4'hF) begin
                    fault("store without all byte enables");
                end
            end
            if (test_done) begin
                if (register_v0 !== exp_v0) begin
                    mismatch("v0", exp_v0, register_v0);
                end
                if (store_count != (exp_has_store ? 1 : 0)) begin
                    mismatch("store count", exp_has_store ? 1 : 0, store_count);
                end else if (exp_has_store) begin
                    if (store_addr !== exp_store_addr) begin
                        mismatch("store address", exp_store_addr, store_addr);
                    end
                    if (store_data !== exp_store_data) begin
                        mismatch("store data", exp_store_data, store_data);
                    end
                end
                if (test_errors == 0) begin
                    pass_count++;
                    $display("PASS %0s (stall %0d%%)", test_name, stall_rate);
                end else begin
                    fail_count++;
                    $display("FAIL %0s (stall %0d%%), %0d errors", test_name, stall_rate,
                             test_errors);
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== bench/mips_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module mips_tb import mips_pkg::*; ();
    localparam int NUM_BASE = 6;
    localparam int NUM_TESTS = 2 * NUM_BASE;
    localparam int MAX_STALL_RUN = 4;
    localparam int STALL_PERCENT = 35;
    localparam word_t DATA_BASE = 32'h0000_1000;

    logic clk;
    logic reset;
    logic waitrequest;
    word_t readdata;
    logic active;
    word_t register_v0;
    word_t address;
    logic read;
    logic write;
    word_t writedata;
    logic [3:0] byteenable;

    word_t prog_mem [16];
    word_t data_mem [16];

    logic [127:0] test_name [NUM_TESTS];
    word_t test_prog [NUM_TESTS][8];
    int test_stall [NUM_TESTS];
    word_t test_v0 [NUM_TESTS];
    logic test_has_store [NUM_TESTS];
    word_t test_st_addr [NUM_TESTS];
    word_t test_st_val [NUM_TESTS];
    int rows;

    logic [127:0] cur_name;
    int cur_stall;
    word_t cur_v0;
    logic cur_has_store;
    word_t cur_st_addr;
    word_t cur_st_data;
    logic test_done;
    int stall_rate;
    int stall_run;
    integer seed;
    int cycle_count;
    int cycle_limit;
    int error_count;
    int pass_count;
    int fail_count;

    mips_cpu_bus dut_i (
        .clk(clk),
        .reset(reset),
        .active(active),
        .register_v0(register_v0),
        .address(address),
        .write(write),
        .read(read),
        .waitrequest(waitrequest),
        .writedata(writedata),
        .byteenable(byteenable),
        .readdata(readdata)
    );

    mips_checker checker_i (
        .clk(clk),
        .reset(reset),
        .active(active),
        .register_v0(register_v0),
        .address(address),
        .read(read),
        .write(write),
        .writedata(writedata),
        .byteenable(byteenable),
        .waitrequest(waitrequest),
        .test_done(test_done),
        .test_name(cur_name),
        .stall_rate(cur_stall),
        .exp_v0(cur_v0),
        .exp_has_store(cur_has_store),
        .exp_store_addr(cur_st_addr),
        .exp_store_data(cur_st_data),
        .error_count(error_count),
        .pass_count(pass_count),
        .fail_count(fail_count)
    );

    function automatic word_t rtype(input logic [5:0] fn, input logic [4:0] rs,
                                    input logic [4:0] rt, input logic [4:0] rd,
                                    input logic [4:0] sh);
        return {6'h00, rs, rt, rd, sh, fn};
    endfunction

    function automatic word_t itype(input logic [5:0] op, input logic [4:0] rs,
                                    input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t jump_to(input word_t target);
        return {6'h02, target[27:2]};
    endfunction

    function automatic word_t prog_addr(input int k);
        return RESET_VECTOR + 4 * k;
    endfunction

    function automatic word_t reverse_bytes(input word_t w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    task automatic add_row(input logic [127:0] name, input word_t v0, input logic has_store,
                           input word_t st_addr, input word_t st_val,
                           input word_t w0, input word_t w1, input word_t w2, input word_t w3,
                           input word_t w4, input word_t w5, input word_t w6, input word_t w7);
        test_name[rows] = name;
        test_stall[rows] = 0;
        test_v0[rows] = v0;
        test_has_store[rows] = has_store;
        test_st_addr[rows] = st_addr;
        test_st_val[rows] = st_val;
        test_prog[rows][0] = w0;
        test_prog[rows][1] = w1;
        test_prog[rows][2] = w2;
        test_prog[rows][3] = w3;
        test_prog[rows][4] = w4;
        test_prog[rows][5] = w5;
        test_prog[rows][6] = w6;
        test_prog[rows][7] = w7;
        rows++;
    endtask

    task automatic build_table();
        word_t r1;
        word_t halt;
        r1 = 32'h1234_5678;
        halt = rtype(FN_JR, 0, 0, 0, 0);
        rows = 0;
        add_row("alu_basic", ((((r1 - 32'hFFFF_FFFD) & r1) ^ 32'hFFFF_FFFD) >> 4), 0, 0, 0,
                itype(OP_LUI, 0, 1, 16'h1234), itype(OP_ORI, 1, 1, 16'h5678),
                itype(OP_ADDIU, 0, 3, 16'hFFFD), rtype(FN_SUBU, 1, 3, 2, 0),
                rtype(FN_AND, 2, 1, 2, 0), rtype(FN_XOR, 2, 3, 2, 0),
                halt, rtype(FN_SRL, 0, 2, 2, 4));
        // -16 sra 2 plus slt result, then xor with (sltu << 8)
        add_row("cmp_shift", (32'hFFFF_FFFC + 32'd1) ^ 32'h0000_0100, 0, 0, 0,
                itype(OP_ADDIU, 0, 1, 16'hFFF0), rtype(FN_SLT, 1, 0, 4, 0),
                rtype(FN_SLTU, 4, 1, 5, 0), rtype(FN_SLL, 0, 5, 5, 8),
                rtype(FN_SRA, 0, 1, 2, 2), rtype(FN_ADDU, 2, 4, 2, 0),
                halt, rtype(FN_XOR, 2, 5, 2, 0));
        add_row("store_load", 32'h8765_4321, 1, DATA_BASE + 32'h8, 32'h8765_4321,
                itype(OP_LUI, 0, 1, 16'h8765), itype(OP_ORI, 1, 1, 16'h4321),
                itype(OP_ADDIU, 0, 5, DATA_BASE[15:0]), itype(OP_SW, 5, 1, 16'h000A),
                itype(OP_LW, 5, 2, 16'h0008), halt, 32'h0, 32'h0);
        add_row("branch_bne", (32'd1 + 32'd2) | 32'h40, 0, 0, 0,
                itype(OP_ADDIU, 0, 1, 16'd7), itype(OP_BEQ, 1, 0, 16'd3),
                itype(OP_ADDIU, 0, 2, 16'd1), itype(OP_BNE, 1, 0, 16'd2),
                itype(OP_ADDIU, 2, 2, 16'd2), itype(OP_ADDIU, 2, 2, 16'h100),
                halt, itype(OP_ORI, 2, 2, 16'h40));
        add_row("branch_beq", (32'h10 + 32'h20) & 32'h0FFF, 0, 0, 0,
                itype(OP_ADDIU, 0, 1, 16'd7), itype(OP_BNE, 1, 1, 16'd3),
                itype(OP_ADDIU, 0, 2, 16'h10), itype(OP_BEQ, 1, 1, 16'd2),
                itype(OP_ADDIU, 2, 2, 16'h20), itype(OP_ADDIU, 2, 2, 16'h400),
                halt, itype(OP_ANDI, 2, 2, 16'h0FFF));
        add_row("jump", 32'd1 + 32'd2 + 32'd4 + 32'd8, 0, 0, 0,
                itype(OP_ADDIU, 0, 2, 16'd1), jump_to(prog_addr(4)),
                itype(OP_ADDIU, 2, 2, 16'd2), itype(OP_ADDIU, 2, 2, 16'h100),
                itype(OP_ADDIU, 2, 2, 16'd4), halt,
                itype(OP_ADDIU, 2, 2, 16'd8), itype(OP_ADDIU, 2, 2, 16'h200));
        for (int t = 0; t < NUM_BASE; t++) begin    // Same programs under stalls
            test_name[t + NUM_BASE] = test_name[t];
            test_stall[t + NUM_BASE] = STALL_PERCENT;
            test_v0[t + NUM_BASE] = test_v0[t];
            test_has_store[t + NUM_BASE] = test_has_store[t];
            test_st_addr[t + NUM_BASE] = test_st_addr[t];
            test_st_val[t + NUM_BASE] = test_st_val[t];
            for (int k = 0; k < 8; k++) begin
                test_prog[t + NUM_BASE][k] = test_prog[t][k];
            end
        end
    endtask

    task automatic load_memory(input int t);
        for (int i = 0; i < 16; i++) begin
            prog_mem[i] = (i < 8) ? reverse_bytes(test_prog[t][i]) : 32'h0;
            data_mem[i] = (DATA_BASE + 4 * i) ^ 32'hC3C3_3C3C;
        end
    endtask

    function automatic word_t mem_word(input word_t addr);
        if (addr[31:16] == RESET_VECTOR[31:16]) begin
            return prog_mem[addr[5:2]];
        end
        return data_mem[addr[5:2]];
    endfunction

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Bus memory with random waitrequest and read data one cycle after acceptance
    always @(posedge clk) begin
        if (read === 1'b1 && !waitrequest) begin
            readdata <= mem_word(address);
        end
        if (write === 1'b1 && !waitrequest && address[31:16] == DATA_BASE[31:16]) begin
            data_mem[address[5:2]] <= writedata;
        end
        if (stall_rate == 0 || stall_run >= MAX_STALL_RUN) begin
            waitrequest <= 1'b0;
            stall_run <= 0;
        end else if ((($random(seed) & 32'h7FFF_FFFF) % 100) < stall_rate) begin
            waitrequest <= 1'b1;
            stall_run <= stall_run + 1;
        end else begin
            waitrequest <= 1'b0;
            stall_run <= 0;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: the core did not halt within %0d cycles", cycle_limit);
            $display("test failed");
            $finish;
        end
    end

    initial begin
        reset = 1'b1;
        waitrequest = 1'b0;
        readdata = '0;
        test_done = 1'b0;
        stall_rate = 0;
        stall_run = 0;
        seed = 64;
        cycle_count = 0;
        cur_name = '0;
        cur_stall = 0;
        cur_v0 = '0;
        cur_has_store = 1'b0;
        cur_st_addr = '0;
        cur_st_data = '0;
        build_table();
        // Up to 3 bus phases per instruction with the longest stall run on each
        cycle_limit = NUM_TESTS * 8 * 3 * (1 + MAX_STALL_RUN) + NUM_TESTS * 20 + 100;

        for (int t = 0; t < NUM_TESTS; t++) begin
            @(posedge clk);
            reset <= 1'b1;
            stall_rate <= 0;
            cur_name <= test_name[t];
            cur_stall <= test_stall[t];
            cur_v0 <= test_v0[t];
            cur_has_store <= test_has_store[t];
            cur_st_addr <= test_st_addr[t];
            cur_st_data <= reverse_bytes(test_st_val[t]);
            load_memory(t);
            repeat (4) @(posedge clk);
            reset <= 1'b0;
            stall_rate <= test_stall[t];
            @(negedge clk);
            while (active !== 1'b0) begin
                @(negedge clk);
            end
            repeat (4) @(posedge clk);    // Idle cycles after halt
            test_done <= 1'b1;
            @(posedge clk);
            test_done <= 1'b0;
        end
        @(posedge clk);

        $display("Tests: %0d passed, %0d failed, %0d errors", pass_count, fail_count,
                 error_count);
        if (error_count == 0 && fail_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
design/mips_pkg.sv
design/mips_decoder.sv
design/mips_alu.sv
design/mips_reg_file.sv
design/mips_control.sv
design/mips_bus_arbiter.sv
design/mips_cpu_bus.sv
bench/mips_checker.sv
bench/mips_tb.sv

// ==== Bender.yml ====
package:
  name: mips_cpu_bus

sources:
  - design/mips_pkg.sv
  - design/mips_decoder.sv
  - design/mips_alu.sv
  - design/mips_reg_file.sv
  - design/mips_control.sv
  - design/mips_bus_arbiter.sv
  - design/mips_cpu_bus.sv
  - target: test
    files:
      - bench/mips_checker.sv
      - bench/mips_tb.sv
